// ==== build.f ====
common/mem_pkg.sv
common/mem_rd_if.sv
mem_stage/load_ctrl.sv
mem_stage/load_align.sv
design/csr_file.sv
design/data_ram.sv
design/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench and the design with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module tb_mem_subsystem -Mdir obj_dir -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0

// ==== verif/tb_mem_subsystem.sv ====
module tb_mem_subsystem;
    import mem_pkg::*;

    // preload plus 64 cycles per operation plus margin
    localparam int CYCLE_LIMIT = RAM_WORDS + 64 * 10 + 200;
    localparam int NUM_LOADS   = 40;
    localparam int NUM_CSR_OPS = 24;
    localparam int LOAD_CYCLES = 6;
    localparam int WAIT_MAX    = 20;

    logic       clk = 1'b0;
    logic       rst_n;
    ld_kind_e   ld_kind;
    alu_op_e    alu_op;
    ext_mode_e  ext_mode;
    xlen_t      src1;
    xlen_t      src2;
    xlen_t      pc;
    xlen_t      ex_result;
    logic       csr_valid;
    csr_addr_t  csr_addr;
    logic       wr_en;
    ram_addr_t  wr_addr;
    xlen_t      wr_data;
    xlen_t      wb_result;
    logic       res_valid;
    logic       mem_idle;
    xlen_t      mepc;
    xlen_t      mcause;
    xlen_t      mtvec;
    xlen_t      mstatus;

    // reference state
    xlen_t       model_mem [RAM_WORDS];
    xlen_t       m_mepc;
    xlen_t       m_mcause;
    xlen_t       m_mtvec;
    xlen_t       m_mstatus;
    logic [31:0] lfsr_state = 32'd41;
    int          cycles = 0;

    mem_subsystem_top mem_subsystem_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_kind   (ld_kind),
        .alu_op    (alu_op),
        .ext_mode  (ext_mode),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .ex_result (ex_result),
        .csr_valid (csr_valid),
        .csr_addr  (csr_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wb_result (wb_result),
        .res_valid (res_valid),
        .mem_idle  (mem_idle),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtvec     (mtvec),
        .mstatus   (mstatus)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic stop_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_run("strobe mismatch");
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output xlen_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic ld_kind_e pick_kind(input logic [1:0] r);
        case (r)
            2'd0: return LD_W;
            2'd1: return LD_D;
            2'd2: return LD_B;
            default: return LD_H;
        endcase
    endfunction

    function automatic ext_mode_e pick_mode(input logic [1:0] r);
        case (r)
            2'd0: return EXT_NONE;
            2'd1: return EXT_SX32;
            2'd2: return EXT_ZX32;
            default: return EXT_SX16;
        endcase
    endfunction

    // width mask first, then the extension rule
    function automatic xlen_t expect_load(input xlen_t word, input ld_kind_e kind,
                                          input ext_mode_e mode);
        xlen_t v;
        case (kind)
            LD_B: v = word & 64'h0000_0000_0000_00ff;
            LD_H: v = word & 64'h0000_0000_0000_ffff;
            LD_W: v = word & 64'h0000_0000_ffff_ffff;
            default: v = word;
        endcase
        case (mode)
            EXT_SX32: v = v[31] ? (v | 64'hffff_ffff_0000_0000)
                                : (v & 64'h0000_0000_ffff_ffff);
            EXT_ZX32: v = v & 64'h0000_0000_ffff_ffff;
            EXT_SX16: v = v[15] ? (v | 64'hffff_ffff_ffff_0000)
                                : (v & 64'h0000_0000_0000_ffff);
            default: ;
        endcase
        return v;
    endfunction

    task automatic apply_csr_model(input alu_op_e op, input csr_addr_t a, input xlen_t s1,
                                   input xlen_t s2, input xlen_t pc_v);
        xlen_t wv;
        logic  mie;
        wv  = (op == ALU_CSRRS) ? (s1 | s2) : s1;
        mie = m_mstatus[3];
        case (op)
            ALU_CSRRW, ALU_CSRRS: begin
                if (a == 12'h341) m_mepc = wv;
                if (a == 12'h342) m_mcause = wv;
                if (a == 12'h305) m_mtvec = wv;
                if (a == 12'h300) m_mstatus = wv;
            end
            ALU_ECALL: begin
                m_mepc       = pc_v;
                m_mcause     = 64'd11;
                m_mstatus[7] = mie;
                m_mstatus[3] = 1'b0;
            end
            ALU_MRET: begin
                m_mstatus[3] = m_mstatus[7];
                m_mstatus[7] = 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic check_csrs();
        check_xlen("mepc", mepc, m_mepc);
        check_xlen("mcause", mcause, m_mcause);
        check_xlen("mtvec", mtvec, m_mtvec);
        check_xlen("mstatus", mstatus, m_mstatus);
    endtask

    // one csr_valid pulse with the registers checked a cycle later
    task automatic csr_op(input alu_op_e op, input csr_addr_t a, input xlen_t s1,
                          input xlen_t s2, input xlen_t pc_v);
        @(posedge clk);
        csr_valid <= 1'b1;
        alu_op    <= op;
        csr_addr  <= a;
        src1      <= s1;
        src2      <= s2;
        pc        <= pc_v;
        apply_csr_model(op, a, s1, s2, pc_v);
        @(posedge clk);
        csr_valid <= 1'b0;
        alu_op    <= ALU_OTHER;
        @(negedge clk);
        check_csrs();
    endtask

    task automatic run_load();
        xlen_t     r;
        xlen_t     s1;
        xlen_t     s2;
        xlen_t     ex;
        xlen_t     addr;
        xlen_t     exp;
        ld_kind_e  kind;
        ext_mode_e mode;
        int        n;
        logic      seen;
        take_bits(2, r);
        kind = pick_kind(r[1:0]);
        take_bits(2, r);
        mode = pick_mode(r[1:0]);
        take_bits(64, s1);
        take_bits(64, s2);
        take_bits(64, ex);
        addr = s1 + s2;
        exp  = expect_load(model_mem[addr[10:3]], kind, mode);
        @(posedge clk);
        ld_kind   <= kind;
        alu_op    <= ALU_ADD;
        ext_mode  <= mode;
        src1      <= s1;
        src2      <= s2;
        ex_result <= ex;
        @(negedge clk);
        check_bit("mem_idle", mem_idle, 1'b1);
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            seen = res_valid;
            // busy through the request and the wait for the response
            if (!seen) check_bit("mem_idle", mem_idle, 1'b0);
        end
        if (!seen) stop_run("load issued but res_valid never rose");
        if (n != LOAD_CYCLES) stop_run("res_valid rose at the wrong cycle after a load");
        check_bit("mem_idle", mem_idle, 1'b1);
        check_xlen("wb_result", wb_result, exp);
        @(posedge clk);
        ld_kind <= LD_NONE;
        @(negedge clk);
        check_bit("res_valid", res_valid, 1'b0);
    endtask

    task automatic run_passthrough();
        xlen_t r;
        take_bits(64, r);
        @(posedge clk);
        ld_kind   <= LD_NONE;
        alu_op    <= ALU_OTHER;
        ex_result <= r;
        @(negedge clk);
        check_xlen("wb_result", wb_result, r);
        check_bit("mem_idle", mem_idle, 1'b1);
        check_bit("res_valid", res_valid, 1'b0);
    endtask

    initial begin
        xlen_t r;
        xlen_t s;
        xlen_t p;
        rst_n     = 1'b0;
        ld_kind   = LD_NONE;
        alu_op    = ALU_OTHER;
        ext_mode  = EXT_NONE;
        src1      = '0;
        src2      = '0;
        pc        = '0;
        ex_result = '0;
        csr_valid = 1'b0;
        csr_addr  = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        m_mepc    = '0;
        m_mcause  = '0;
        m_mtvec   = '0;
        m_mstatus = 64'h0000_0000_a000_1800;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("mem_idle", mem_idle, 1'b1);
        check_bit("res_valid", res_valid, 1'b0);
        check_csrs();

        for (int i = 0; i < RAM_WORDS; i++) begin
            take_bits(64, r);
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= i[7:0];
            wr_data <= r;
            model_mem[i] = r;
        end
        @(posedge clk);
        wr_en <= 1'b0;

        for (int i = 0; i < NUM_LOADS; i++) begin
            run_load();
        end

        for (int i = 0; i < 8; i++) begin
            run_passthrough();
        end

        // address walks all four registers, data and op are random
        for (int i = 0; i < NUM_CSR_OPS; i++) begin
            take_bits(1, r);
            take_bits(64, s);
            take_bits(64, p);
            case (i % 4)
                0: csr_op(r[0] ? ALU_CSRRS : ALU_CSRRW, CSR_MEPC, s, p, '0);
                1: csr_op(r[0] ? ALU_CSRRS : ALU_CSRRW, CSR_MCAUSE, s, p, '0);
                2: csr_op(r[0] ? ALU_CSRRS : ALU_CSRRW, CSR_MTVEC, s, p, '0);
                default: csr_op(r[0] ? ALU_CSRRS : ALU_CSRRW, CSR_MSTATUS, s, p, '0);
            endcase
        end
        take_bits(64, s);
        csr_op(ALU_CSRRW, 12'h7c0, s, '0, '0);
        csr_op(ALU_CSRRS, 12'h7c0, s, ~s, '0);

        // trap entry and return with MIE set and then clear
        for (int i = 0; i < 2; i++) begin
            take_bits(64, r);
            r[3] = ~i[0];
            r[7] = i[0];
            csr_op(ALU_CSRRW, CSR_MSTATUS, r, '0, '0);
            take_bits(64, p);
            csr_op(ALU_ECALL, '0, '0, '0, p);
            check_xlen("mepc", mepc, p);
            check_xlen("mcause", mcause, 64'd11);
            csr_op(ALU_MRET, '0, '0, '0, '0);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== design/mem_subsystem_top.sv ====
module mem_subsystem_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::ld_kind_e   ld_kind,
    input  mem_pkg::alu_op_e    alu_op,
    input  mem_pkg::ext_mode_e  ext_mode,
    input  mem_pkg::xlen_t      src1,
    input  mem_pkg::xlen_t      src2,
    input  mem_pkg::xlen_t      pc,
    input  mem_pkg::xlen_t      ex_result,
    input  logic                csr_valid,
    input  mem_pkg::csr_addr_t  csr_addr,
    input  logic                wr_en,
    input  mem_pkg::ram_addr_t  wr_addr,
    input  mem_pkg::xlen_t      wr_data,
    output mem_pkg::xlen_t      wb_result,
    output logic                res_valid,
    output logic                mem_idle,
    output mem_pkg::xlen_t      mepc,
    output mem_pkg::xlen_t      mcause,
    output mem_pkg::xlen_t      mtvec,
    output mem_pkg::xlen_t      mstatus
);
    import mem_pkg::*;

    xlen_t    ld_data;
    ld_kind_e ld_kind_q;
    logic     load_active;

    mem_rd_if rd_bus ();

    // registered kind while a request is out, decoded kind otherwise
    assign load_active = mem_idle ? (ld_kind != LD_NONE) : (ld_kind_q != LD_NONE);

    load_ctrl u_load_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_kind   (ld_kind),
        .src1      (src1),
        .src2      (src2),
        .rd        (rd_bus),
        .ld_data   (ld_data),
        .ld_kind_q (ld_kind_q),
        .res_valid (res_valid),
        .mem_idle  (mem_idle)
    );

    load_align u_load_align (
        .ld_kind_q   (ld_kind_q),
        .ld_data     (ld_data),
        .ext_mode    (ext_mode),
        .load_active (load_active),
        .ex_result   (ex_result),
        .wb_result   (wb_result)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_valid (csr_valid),
        .alu_op    (alu_op),
        .csr_addr  (csr_addr),
        .src1      (src1),
        .src2      (src2),
        .pc        (pc),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtvec     (mtvec),
        .mstatus   (mstatus)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd      (rd_bus)
    );

endmodule

// ==== design/data_ram.sv ====
module data_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  mem_pkg::ram_addr_t wr_addr,
    input  mem_pkg::xlen_t     wr_data,
    mem_rd_if.responder        rd
);
    import mem_pkg::*;

    xlen_t                  mem [RAM_WORDS];
    logic [RAM_LATENCY-1:0] pipe_v;
    ram_addr_t              pipe_idx [RAM_LATENCY];
    mem_tag_t               pipe_tag [RAM_LATENCY];
    logic                   in_flight;

    // preload port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // done comes RAM_LATENCY edges after the edge that takes req
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_v  <= '0;
            rd.done <= 1'b0;
        end else begin
            pipe_v  <= {pipe_v[RAM_LATENCY-2:0], rd.req};
            rd.done <= pipe_v[RAM_LATENCY-1];
        end
    end

    // index and tag ride along with the valid bits
    always_ff @(posedge clk) begin
        pipe_idx[0] <= rd.addr[RAM_LSB +: RAM_AW];
        pipe_tag[0] <= rd.tag;
        for (int i = 1; i < RAM_LATENCY; i++) begin
            pipe_idx[i] <= pipe_idx[i-1];
            pipe_tag[i] <= pipe_tag[i-1];
        end
        // array read when the response goes out
        rd.rdata <= mem[pipe_idx[RAM_LATENCY-1]];
        rd.rtag  <= pipe_tag[RAM_LATENCY-1];
    end

    assign in_flight = (|pipe_v) || rd.done;

    // the requester keeps a single load outstanding
    a_one_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.req |-> !in_flight
    ) else $error("data_ram: req while a read is in flight");

endmodule

// ==== design/csr_file.sv ====
module csr_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               csr_valid,
    input  mem_pkg::alu_op_e   alu_op,
    input  mem_pkg::csr_addr_t csr_addr,
    input  mem_pkg::xlen_t     src1,
    input  mem_pkg::xlen_t     src2,
    input  mem_pkg::xlen_t     pc,
    output mem_pkg::xlen_t     mepc,
    output mem_pkg::xlen_t     mcause,
    output mem_pkg::xlen_t     mtvec,
    output mem_pkg::xlen_t     mstatus
);
    import mem_pkg::*;

    xlen_t wdata;

    // csrrs sets bits, csrrw replaces
    assign wdata = (alu_op == ALU_CSRRS) ? (src1 | src2) : src1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc    <= '0;
            mcause  <= '0;
            mtvec   <= '0;
            mstatus <= MSTATUS_RESET;
        end else if (csr_valid) begin
            case (alu_op)
                ALU_CSRRW, ALU_CSRRS: begin
                    case (csr_addr)
                        CSR_MEPC: begin
                            mepc <= wdata;
                        end
                        CSR_MCAUSE: begin
                            mcause <= wdata;
                        end
                        CSR_MTVEC: begin
                            mtvec <= wdata;
                        end
                        CSR_MSTATUS: begin
                            mstatus <= wdata;
                        end
                        default: begin
                            mepc <= mepc;
                        end
                    endcase
                end
                ALU_ECALL: begin
                    // trap entry, MIE saved in MPIE
                    mepc                  <= pc;
                    mcause                <= MCAUSE_ECALL;
                    mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
                    mstatus[MSTATUS_MIE]  <= 1'b0;
                end
                ALU_MRET: begin
                    // restore MIE, MPIE back to one
                    mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
                    mstatus[MSTATUS_MPIE] <= 1'b1;
                end
                default: begin
                    mstatus <= mstatus;
                end
            endcase
        end
    end

    // loads never reach the CSR port
    a_no_csr_on_add: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_valid |-> (alu_op != ALU_ADD)
    ) else $error("csr_file: csr_valid with ALU_ADD");

endmodule

// ==== mem_stage/load_align.sv ====
module load_align (
    input  mem_pkg::ld_kind_e  ld_kind_q,
    input  mem_pkg::xlen_t     ld_data,
    input  mem_pkg::ext_mode_e ext_mode,
    input  logic               load_active,
    input  mem_pkg::xlen_t     ex_result,
    output mem_pkg::xlen_t     wb_result
);
    import mem_pkg::*;

    xlen_t raw;
    xlen_t ext;

    // cut the loaded field out, upper bits zero
    always_comb begin
        case (ld_kind_q)
            LD_W: begin
                raw = {32'b0, ld_data[31:0]};
            end
            LD_D: begin
                raw = ld_data;
            end
            LD_B: begin
                raw = {56'b0, ld_data[7:0]};
            end
            LD_H: begin
                raw = {48'b0, ld_data[15:0]};
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    always_comb begin
        case (ext_mode)
            EXT_SX32: begin
                ext = {{32{raw[31]}}, raw[31:0]};
            end
            EXT_ZX32: begin
                ext = {32'b0, raw[31:0]};
            end
            EXT_SX16: begin
                ext = {{48{raw[15]}}, raw[15:0]};
            end
            default: begin
                ext = raw;
            end
        endcase
    end

    // non-loads bypass the stage
    assign wb_result = load_active ? ext : ex_result;

endmodule

// ==== mem_stage/load_ctrl.sv ====
module load_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::ld_kind_e ld_kind,
    input  mem_pkg::xlen_t    src1,
    input  mem_pkg::xlen_t    src2,
    mem_rd_if.requester       rd,
    output mem_pkg::xlen_t    ld_data,
    output mem_pkg::ld_kind_e ld_kind_q,
    output logic              res_valid,
    output logic              mem_idle
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        MEM  = 2'd1,
        EN   = 2'd2,
        FN   = 2'd3
    } state_e;

    state_e   state;
    state_e   state_nxt;
    xlen_t    addr_q;
    mem_tag_t tag_q;
    logic     start;
    logic     rsp_hit;

    // a load is taken only from IDLE
    assign start = (state == IDLE) && (ld_kind != LD_NONE);

    // responses carrying a foreign tag are dropped
    assign rsp_hit = rd.done && (rd.rtag == tag_q);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = MEM;
                end
            end
            MEM: begin
                state_nxt = EN;
            end
            EN: begin
                if (rsp_hit) begin
                    state_nxt = FN;
                end
            end
            FN: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ld_kind_q <= LD_NONE;
            tag_q     <= '0;
        end else begin
            state <= state_nxt;
            if (start) begin
                ld_kind_q <= ld_kind;
                tag_q     <= LOAD_TAG;
            end
        end
    end

    // effective address and returned word
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= src1 + src2;
        end
        if ((state == EN) && rsp_hit) begin
            ld_data <= rd.rdata;
        end
    end

    assign rd.req  = (state == MEM);
    assign rd.addr = addr_q;
    assign rd.tag  = tag_q;

    assign res_valid = (state == FN);
    // busy while the request is out
    assign mem_idle  = !((state == MEM) || (state == EN));

    // req follows an accepted load by one cycle and carries the load tag
    a_req_only_in_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.req |-> ($past(start) && (rd.tag == LOAD_TAG))
    ) else $error("load_ctrl: req without an accepted load");

    // a response with no load pending means the RAM and the FSM disagree
    a_no_done_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd.done |-> (state != IDLE)
    ) else $error("load_ctrl: done seen while IDLE");

endmodule

// ==== common/mem_rd_if.sv ====
interface mem_rd_if;
    import mem_pkg::*;

    // request, a single-cycle pulse
    logic     req;
    xlen_t    addr;
    mem_tag_t tag;

    // response, tag echoed back
    logic     done;
    xlen_t    rdata;
    mem_tag_t rtag;

    modport requester (
        output req, addr, tag,
        input  done, rdata, rtag
    );

    modport responder (
        input  req, addr, tag,
        output done, rdata, rtag
    );

endinterface

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // widths fixed by the RV64 ISA
    localparam int XLEN   = 64;
    localparam int CSR_AW = 12;
    localparam int TAG_W  = 4;

    // data RAM geometry, 64-bit words
    localparam int RAM_AW      = 8;
    localparam int RAM_WORDS   = 256;
    localparam int RAM_LSB     = 3;
    localparam int RAM_LATENCY = 3;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [CSR_AW-1:0] csr_addr_t;
    typedef logic [TAG_W-1:0]  mem_tag_t;
    typedef logic [RAM_AW-1:0] ram_addr_t;

    // ALU_ADD together with a load kind is a load
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_CSRRS = 3'd1,
        ALU_CSRRW = 3'd2,
        ALU_ECALL = 3'd3,
        ALU_MRET  = 3'd4,
        ALU_OTHER = 3'd5
    } alu_op_e;

    // load width as decoded by the execute stage
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_W    = 3'd1,
        LD_D    = 3'd2,
        LD_B    = 3'd4,
        LD_H    = 3'd6
    } ld_kind_e;

    typedef enum logic [1:0] {
        EXT_NONE = 2'd0,
        EXT_SX32 = 2'd1,
        EXT_ZX32 = 2'd2,
        EXT_SX16 = 2'd3
    } ext_mode_e;

    // machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam xlen_t MSTATUS_RESET = 64'h0000_0000_a000_1800;
    localparam xlen_t MCAUSE_ECALL  = 64'd11;

    // mstatus.MIE and mstatus.MPIE
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // tag carried by every load request
    localparam mem_tag_t LOAD_TAG = 4'd2;

endpackage
